/* all.f */
rtl/exu_pkg.sv
rtl/exu_cmd_queue.sv
rtl/exu_regfile.sv
rtl/exu_ialu.sv
rtl/exu_result.sv
rtl/exu_top.sv
testbench/exu_chk.sv
testbench/tb_exu.sv

/* rtl/exu_cmd_queue.sv */
// Command queue
// Holds one decoded command between the decode stage and execution,
// with a req/rdy handshake and a flush on every PC redirect

`timescale 1ns/100ps

module exu_cmd_queue (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Decode side
    input  logic                                   cmd_req,        // Command offered
    output logic                                   cmd_rdy,        // Queue can take it
    input  exu_pkg::ialu_op_e                      ialu_op,
    input  exu_pkg::ialu_cmd_e                     ialu_cmd,
    input  exu_pkg::sum2_op_e                      sum2_op,
    input  exu_pkg::rd_wb_sel_e                    rd_wb_sel,
    input  logic                                   jump_req,
    input  logic                                   branch_req,
    input  logic [exu_pkg::reg_addr_width-1:0]     rs1_addr,
    input  logic [exu_pkg::reg_addr_width-1:0]     rs2_addr,
    input  logic [exu_pkg::reg_addr_width-1:0]     rd_addr,
    input  logic [exu_pkg::xlen-1:0]               imm,

    // Control from result unit
    input  logic                                   new_pc_req,     // Redirect this cycle
    input  logic                                   init_done,      // Reset exit finished

    // Stored command
    output logic                                   queue_vd,       // Entry valid
    output exu_pkg::ialu_op_e                      q_ialu_op,
    output exu_pkg::ialu_cmd_e                     q_ialu_cmd,
    output exu_pkg::sum2_op_e                      q_sum2_op,
    output exu_pkg::rd_wb_sel_e                    q_rd_wb_sel,
    output logic                                   q_jump_req,
    output logic                                   q_branch_req,
    output logic [exu_pkg::reg_addr_width-1:0]     q_rs1_addr,
    output logic [exu_pkg::reg_addr_width-1:0]     q_rs2_addr,
    output logic [exu_pkg::reg_addr_width-1:0]     q_rd_addr,
    output logic [exu_pkg::xlen-1:0]               q_imm
);

logic cmd_hs;                                               // Handshake this edge

// Every command retires in one cycle, only reset exit holds off decode
assign cmd_rdy = init_done;
assign cmd_hs  = cmd_req & cmd_rdy;

// --------------------
// Valid bit
// --------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        queue_vd <= 1'b0;
    end else begin
        queue_vd <= cmd_hs & ~new_pc_req;                   // Drop a command behind a redirect
    end
end

// --------------------
// Command fields
// --------------------
always_ff @(posedge clk) begin
    if (cmd_hs) begin
        q_ialu_op    <= ialu_op;
        q_ialu_cmd   <= ialu_cmd;
        q_sum2_op    <= sum2_op;
        q_rd_wb_sel  <= rd_wb_sel;
        q_jump_req   <= jump_req;
        q_branch_req <= branch_req;
        q_rs1_addr   <= rs1_addr;
        q_rs2_addr   <= rs2_addr;
        q_rd_addr    <= rd_addr;
        q_imm        <= imm;
    end
end

endmodule : exu_cmd_queue

/* rtl/exu_ialu.sv */
// Integer ALU
// Arithmetic, logic, shifts and set-less-than, the branch comparator
// and the second adder used for jump, branch and auipc targets

`timescale 1ns/100ps

module exu_ialu (
    input  exu_pkg::ialu_op_e              ialu_op,        // rs2 or imm
    input  exu_pkg::ialu_cmd_e             ialu_cmd,
    input  exu_pkg::sum2_op_e              sum2_op,        // PC or rs1
    input  logic [exu_pkg::xlen-1:0]       rs1_data,
    input  logic [exu_pkg::xlen-1:0]       rs2_data,
    input  logic [exu_pkg::xlen-1:0]       imm,
    input  logic [exu_pkg::xlen-1:0]       curr_pc,
    output logic [exu_pkg::xlen-1:0]       ialu_res,       // ALU result
    output logic                           ialu_cmp,       // Branch condition
    output logic [exu_pkg::xlen-1:0]       sum2_res        // Target or address
);

localparam int msb = exu_pkg::xlen - 1;

logic [exu_pkg::xlen-1:0]   op1;
logic [exu_pkg::xlen-1:0]   op2;
logic [exu_pkg::xlen:0]     diff;                           // Extra bit is the borrow
logic [4:0]                 shamt;
logic                       eq;
logic                       lt;
logic                       ltu;
logic [exu_pkg::xlen-1:0]   sum2_op1;

// --------------------
// Operand select
// --------------------
assign op1      = rs1_data;
assign op2      = (ialu_op == exu_pkg::ialu_op_reg_reg) ? rs2_data : imm;
assign sum2_op1 = (sum2_op == exu_pkg::sum2_op_pc_imm) ? curr_pc : rs1_data;

// --------------------
// Shared subtractor
// --------------------
assign diff  = {1'b0, op1} - {1'b0, op2};
assign eq    = (op1 == op2);
assign ltu   = diff[exu_pkg::xlen];                         // Borrow out
assign lt    = (op1[msb] ^ op2[msb]) ? op1[msb] : diff[msb]; // Signs differ or sub sign
assign shamt = op2[4:0];

// Branch comparator
always_comb begin
    case (ialu_cmd)
        exu_pkg::ialu_cmd_eq   : ialu_cmp = eq;
        exu_pkg::ialu_cmd_ne   : ialu_cmp = ~eq;
        exu_pkg::ialu_cmd_slt  : ialu_cmp = lt;             // Also blt
        exu_pkg::ialu_cmd_ge   : ialu_cmp = ~lt;
        exu_pkg::ialu_cmd_sltu : ialu_cmp = ltu;            // Also bltu
        exu_pkg::ialu_cmd_geu  : ialu_cmp = ~ltu;
        default                : ialu_cmp = 1'b0;
    endcase
end

// --------------------
// Result mux
// --------------------
always_comb begin
    case (ialu_cmd)
        exu_pkg::ialu_cmd_add : ialu_res = op1 + op2;
        exu_pkg::ialu_cmd_sub : ialu_res = diff[msb:0];
        exu_pkg::ialu_cmd_and : ialu_res = op1 & op2;
        exu_pkg::ialu_cmd_or  : ialu_res = op1 | op2;
        exu_pkg::ialu_cmd_xor : ialu_res = op1 ^ op2;
        exu_pkg::ialu_cmd_sll : ialu_res = op1 << shamt;
        exu_pkg::ialu_cmd_srl : ialu_res = op1 >> shamt;
        exu_pkg::ialu_cmd_sra : ialu_res = $signed(op1) >>> shamt;
        exu_pkg::ialu_cmd_none: ialu_res = '0;
        default               : ialu_res = {{msb{1'b0}}, ialu_cmp}; // slt, sltu and compares
    endcase
end

// Second adder
assign sum2_res = sum2_op1 + imm;

endmodule : exu_ialu

/* rtl/exu_pkg.sv */
// Execution stage package
// Widths, PC vectors and the command encodings shared by the
// queue, ALU and result unit

package exu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int xlen           = 32;                  // Data and PC width
    localparam int reg_addr_width = 5;                   // 32-entry register file

    // --------------------
    // PC constants
    // --------------------
    localparam logic [xlen-1:0] rst_vector  = 32'h0000_0200; // Loaded at reset exit
    localparam logic [xlen-1:0] trap_vector = 32'h0000_0100; // Misaligned target trap
    localparam logic [xlen-1:0] jump_mask   = 32'hffff_fffe; // Clears bit 0 of a target

    // --------------------
    // Command encodings
    // --------------------

    // ALU operation
    // slt and sltu double as the blt and bltu compares
    typedef enum logic [3:0] {
        ialu_cmd_none = 4'd0,                             // No ALU work
        ialu_cmd_add  = 4'd1,
        ialu_cmd_sub  = 4'd2,
        ialu_cmd_and  = 4'd3,
        ialu_cmd_or   = 4'd4,
        ialu_cmd_xor  = 4'd5,
        ialu_cmd_sll  = 4'd6,                             // Shift by low 5 bits
        ialu_cmd_srl  = 4'd7,
        ialu_cmd_sra  = 4'd8,
        ialu_cmd_slt  = 4'd9,                             // Signed less than
        ialu_cmd_sltu = 4'd10,                            // Unsigned less than
        ialu_cmd_eq   = 4'd11,                            // Branch compares
        ialu_cmd_ne   = 4'd12,
        ialu_cmd_ge   = 4'd13,
        ialu_cmd_geu  = 4'd14
    } ialu_cmd_e;

    // Second ALU operand
    typedef enum logic {
        ialu_op_reg_reg = 1'b0,                           // rs1 op rs2
        ialu_op_reg_imm = 1'b1                            // rs1 op imm
    } ialu_op_e;

    // First input of the second adder
    typedef enum logic {
        sum2_op_pc_imm  = 1'b0,                           // PC + imm for jal, branches, auipc
        sum2_op_reg_imm = 1'b1                            // rs1 + imm for jalr
    } sum2_op_e;

    // Write-back source
    typedef enum logic [2:0] {
        rd_wb_none   = 3'd0,                              // No rd write
        rd_wb_ialu   = 3'd1,                              // ALU result
        rd_wb_sum2   = 3'd2,                              // Second adder
        rd_wb_imm    = 3'd3,                              // lui
        rd_wb_inc_pc = 3'd4                               // Link address
    } rd_wb_sel_e;

endpackage : exu_pkg

/* rtl/exu_regfile.sv */
// Integer register file
// 32 x 32 bits, x0 reads as zero, two combinational read ports and
// one write port

`timescale 1ns/100ps

module exu_regfile (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [exu_pkg::reg_addr_width-1:0]     rs1_addr,   // Read port 1
    output logic [exu_pkg::xlen-1:0]               rs1_data,
    input  logic [exu_pkg::reg_addr_width-1:0]     rs2_addr,   // Read port 2
    output logic [exu_pkg::xlen-1:0]               rs2_data,
    input  logic                                   w_req,      // Write port
    input  logic [exu_pkg::reg_addr_width-1:0]     w_addr,
    input  logic [exu_pkg::xlen-1:0]               w_data
);

logic [exu_pkg::xlen-1:0] regs [1:31];                      // x1..x31 only

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (w_req & (w_addr != '0)) begin              // x0 writes dropped
        regs[w_addr] <= w_data;
    end
end

// Combinational reads so the next command sees the last write
assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule : exu_regfile

/* rtl/exu_result.sv */
// Result unit
// Owns the PC and the reset-exit sequencer, picks the next PC, raises
// the misaligned-target exception and selects the write-back data

`timescale 1ns/100ps

module exu_result (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Queued command
    input  logic                                   queue_vd,
    input  logic                                   jump_req,
    input  logic                                   branch_req,
    input  exu_pkg::rd_wb_sel_e                    rd_wb_sel,
    input  logic [exu_pkg::reg_addr_width-1:0]     rd_addr,
    input  logic [exu_pkg::xlen-1:0]               imm,

    // ALU results
    input  logic [exu_pkg::xlen-1:0]               ialu_res,
    input  logic                                   ialu_cmp,
    input  logic [exu_pkg::xlen-1:0]               sum2_res,

    // PC and control
    output logic [exu_pkg::xlen-1:0]               curr_pc,
    output logic                                   new_pc_req,  // Redirect request
    output logic [exu_pkg::xlen-1:0]               new_pc,
    output logic                                   init_done,   // Reset exit over
    output logic                                   exc_req,     // Misaligned target
    output logic                                   instret,     // Command retired

    // Write-back
    output logic                                   rd_w_req,
    output logic [exu_pkg::reg_addr_width-1:0]     rd_w_addr,
    output logic [exu_pkg::xlen-1:0]               rd_w_data
);

logic [3:0]                 init_pc_v;                      // Reset-exit shifter
logic                       init_pc;                        // One-cycle reset vector pulse
logic                       take_jb;                        // Jump or taken branch
logic [exu_pkg::xlen-1:0]   jb_target;
logic [exu_pkg::xlen-1:0]   inc_pc;

// --------------------
// Reset exit
// --------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        init_pc_v <= '0;
    end else if (~&init_pc_v) begin
        init_pc_v <= {init_pc_v[2:0], 1'b1};                // Fills one bit per edge
    end
end

assign init_pc   = ~init_pc_v[3] & init_pc_v[2];            // After third edge
assign init_done = init_pc_v[3];

// --------------------
// Transfer and exception
// --------------------
assign take_jb   = queue_vd & (jump_req | (branch_req & ialu_cmp));
assign jb_target = sum2_res & exu_pkg::jump_mask;
assign exc_req   = take_jb & jb_target[1];                  // Not word aligned
assign instret   = queue_vd;                                // Single-cycle execute
assign inc_pc    = curr_pc + exu_pkg::xlen'(4);

// Exception also redirects so the queue gets flushed
assign new_pc_req = init_pc | take_jb;

always_comb begin
    if (init_pc) begin
        new_pc = exu_pkg::rst_vector;
    end else if (exc_req) begin
        new_pc = exu_pkg::trap_vector;
    end else begin
        new_pc = jb_target;
    end
end

// PC moves at the edge ending a retire cycle
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        curr_pc <= exu_pkg::rst_vector;
    end else if (instret) begin
        curr_pc <= new_pc_req ? new_pc : inc_pc;
    end
end

// --------------------
// Write-back
// --------------------
assign rd_w_req  = queue_vd & (rd_wb_sel != exu_pkg::rd_wb_none) & ~exc_req;
assign rd_w_addr = rd_addr;

always_comb begin
    case (rd_wb_sel)
        exu_pkg::rd_wb_sum2   : rd_w_data = sum2_res;
        exu_pkg::rd_wb_imm    : rd_w_data = imm;
        exu_pkg::rd_wb_inc_pc : rd_w_data = inc_pc;        // Link address
        default               : rd_w_data = ialu_res;
    endcase
end

endmodule : exu_result

/* rtl/exu_top.sv */
// Execution stage top
// Connects the command queue, register file, integer ALU and
// result unit of the RV32I execution stage

`timescale 1ns/100ps

module exu_top (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Decode side
    input  logic                                   cmd_req,
    output logic                                   cmd_rdy,
    input  exu_pkg::ialu_op_e                      ialu_op,
    input  exu_pkg::ialu_cmd_e                     ialu_cmd,
    input  exu_pkg::sum2_op_e                      sum2_op,
    input  exu_pkg::rd_wb_sel_e                    rd_wb_sel,
    input  logic                                   jump_req,
    input  logic                                   branch_req,
    input  logic [exu_pkg::reg_addr_width-1:0]     rs1_addr,
    input  logic [exu_pkg::reg_addr_width-1:0]     rs2_addr,
    input  logic [exu_pkg::reg_addr_width-1:0]     rd_addr,
    input  logic [exu_pkg::xlen-1:0]               imm,

    // Status and PC
    output logic                                   instret,
    output logic                                   exc_req,
    output logic                                   new_pc_req,
    output logic [exu_pkg::xlen-1:0]               new_pc,
    output logic [exu_pkg::xlen-1:0]               curr_pc,

    // Write-back
    output logic                                   rd_w_req,
    output logic [exu_pkg::reg_addr_width-1:0]     rd_w_addr,
    output logic [exu_pkg::xlen-1:0]               rd_w_data
);

// --------------------
// Internal nets
// --------------------
logic                                   queue_vd;
exu_pkg::ialu_op_e                      q_ialu_op;
exu_pkg::ialu_cmd_e                     q_ialu_cmd;
exu_pkg::sum2_op_e                      q_sum2_op;
exu_pkg::rd_wb_sel_e                    q_rd_wb_sel;
logic                                   q_jump_req;
logic                                   q_branch_req;
logic [exu_pkg::reg_addr_width-1:0]     q_rs1_addr;
logic [exu_pkg::reg_addr_width-1:0]     q_rs2_addr;
logic [exu_pkg::reg_addr_width-1:0]     q_rd_addr;
logic [exu_pkg::xlen-1:0]               q_imm;
logic [exu_pkg::xlen-1:0]               rs1_data;
logic [exu_pkg::xlen-1:0]               rs2_data;
logic [exu_pkg::xlen-1:0]               ialu_res;
logic                                   ialu_cmp;
logic [exu_pkg::xlen-1:0]               sum2_res;
logic                                   init_done;

exu_cmd_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_req      (cmd_req),
    .cmd_rdy      (cmd_rdy),
    .ialu_op      (ialu_op),
    .ialu_cmd     (ialu_cmd),
    .sum2_op      (sum2_op),
    .rd_wb_sel    (rd_wb_sel),
    .jump_req     (jump_req),
    .branch_req   (branch_req),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rd_addr      (rd_addr),
    .imm          (imm),
    .new_pc_req   (new_pc_req),       // Flush on redirect
    .init_done    (init_done),
    .queue_vd     (queue_vd),
    .q_ialu_op    (q_ialu_op),
    .q_ialu_cmd   (q_ialu_cmd),
    .q_sum2_op    (q_sum2_op),
    .q_rd_wb_sel  (q_rd_wb_sel),
    .q_jump_req   (q_jump_req),
    .q_branch_req (q_branch_req),
    .q_rs1_addr   (q_rs1_addr),
    .q_rs2_addr   (q_rs2_addr),
    .q_rd_addr    (q_rd_addr),
    .q_imm        (q_imm)
);

exu_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (q_rs1_addr),
    .rs1_data (rs1_data),
    .rs2_addr (q_rs2_addr),
    .rs2_data (rs2_data),
    .w_req    (rd_w_req),
    .w_addr   (rd_w_addr),
    .w_data   (rd_w_data)
);

exu_ialu u_ialu (
    .ialu_op  (q_ialu_op),
    .ialu_cmd (q_ialu_cmd),
    .sum2_op  (q_sum2_op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (q_imm),
    .curr_pc  (curr_pc),
    .ialu_res (ialu_res),
    .ialu_cmp (ialu_cmp),
    .sum2_res (sum2_res)
);

exu_result u_result (
    .clk        (clk),
    .rst_n      (rst_n),
    .queue_vd   (queue_vd),
    .jump_req   (q_jump_req),
    .branch_req (q_branch_req),
    .rd_wb_sel  (q_rd_wb_sel),
    .rd_addr    (q_rd_addr),
    .imm        (q_imm),
    .ialu_res   (ialu_res),
    .ialu_cmp   (ialu_cmp),
    .sum2_res   (sum2_res),
    .curr_pc    (curr_pc),
    .new_pc_req (new_pc_req),
    .new_pc     (new_pc),
    .init_done  (init_done),
    .exc_req    (exc_req),
    .instret    (instret),
    .rd_w_req   (rd_w_req),
    .rd_w_addr  (rd_w_addr),
    .rd_w_data  (rd_w_data)
);

endmodule : exu_top

/* run.sh */
#!/usr/bin/env bash
# Build the execution stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_exu -f all.f; then
    echo "Verilator build failed"
    exit 1
fi

# Raised error limit lets the run reach its closing line after an assertion error
sim_out=$(./obj_dir/Vtb_exu +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF '>>> PASS' <<< "$sim_out"; then
    exit 0
fi
exit 1

/* testbench/exu_chk.sv */
// Protocol checker for the execution stage
// Bound into exu_top, watches reset exit, redirect and retire rules

`timescale 1ns/100ps

module exu_chk (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_req,
    input  logic                       cmd_rdy,
    input  logic                       instret,
    input  logic                       exc_req,
    input  logic                       rd_w_req,
    input  logic                       new_pc_req,
    input  logic [exu_pkg::xlen-1:0]   new_pc
);

int fail_cnt = 0;                                   // Failed assertion count

// Decode opens only after the reset vector pulse
rdy_after_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> $past(new_pc_req))
    else begin
        $error("cmd_rdy rose without a reset-exit pulse before it");
        fail_cnt++;
    end

// Trap suppresses the write-back
exc_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
    !(exc_req && rd_w_req))
    else begin
        $error("exc_req and rd_w_req high together");
        fail_cnt++;
    end

// Redirect target is halfword aligned
pc_bit0_clear: assert property (@(posedge clk) disable iff (!rst_n)
    new_pc_req |-> !new_pc[0])
    else begin
        $error("new_pc bit 0 set during new_pc_req");
        fail_cnt++;
    end

// A retire needs a handshake one edge earlier
retire_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    instret |-> $past(cmd_req && cmd_rdy))
    else begin
        $error("instret without a command loaded the cycle before");
        fail_cnt++;
    end

endmodule : exu_chk

bind exu_top exu_chk chk0 (.*);

/* testbench/tb_exu.sv */
// Execution stage testbench
// Sends decoded commands into exu_top and checks write-back, redirect
// and PC against a register file and PC model

`timescale 1ns/100ps

module tb_exu;

localparam int max_cycles = 4000;                   // About 720 command cycles plus margin

logic                                clk = 1'b0;
logic                                rst_n;
logic                                cmd_req;
logic                                cmd_rdy;
exu_pkg::ialu_op_e                   ialu_op;
exu_pkg::ialu_cmd_e                  ialu_cmd;
exu_pkg::sum2_op_e                   sum2_op;
exu_pkg::rd_wb_sel_e                 rd_wb_sel;
logic                                jump_req;
logic                                branch_req;
logic [exu_pkg::reg_addr_width-1:0]  rs1_addr;
logic [exu_pkg::reg_addr_width-1:0]  rs2_addr;
logic [exu_pkg::reg_addr_width-1:0]  rd_addr;
logic [exu_pkg::xlen-1:0]            imm;
logic                                instret;
logic                                exc_req;
logic                                new_pc_req;
logic [exu_pkg::xlen-1:0]            new_pc;
logic [exu_pkg::xlen-1:0]            curr_pc;
logic                                rd_w_req;
logic [exu_pkg::reg_addr_width-1:0]  rd_w_addr;
logic [exu_pkg::xlen-1:0]            rd_w_data;

logic [31:0]         mreg [32];                     // Model register file, x0 never written
logic [31:0]         mpc;                           // Model PC
logic                p_vld;                         // Command executing this cycle
int                  errors = 0;
int                  drops = 0;                     // Commands lost behind a redirect
int                  timeouts = 0;
int                  cycles = 0;
exu_pkg::ialu_cmd_e  br_cmds [6] = '{exu_pkg::ialu_cmd_eq, exu_pkg::ialu_cmd_ne,
                                     exu_pkg::ialu_cmd_slt, exu_pkg::ialu_cmd_ge,
                                     exu_pkg::ialu_cmd_sltu, exu_pkg::ialu_cmd_geu};

exu_top dut0 (.*);

always #20 clk = ~clk;                              // 40 ns period

// --------------------
// Reference model
// --------------------
function automatic logic [31:0] alu_model(exu_pkg::ialu_cmd_e c, logic [31:0] a, logic [31:0] b);
    case (c)
        exu_pkg::ialu_cmd_add  : return a + b;
        exu_pkg::ialu_cmd_sub  : return a - b;
        exu_pkg::ialu_cmd_and  : return a & b;
        exu_pkg::ialu_cmd_or   : return a | b;
        exu_pkg::ialu_cmd_xor  : return a ^ b;
        exu_pkg::ialu_cmd_sll  : return a << b[4:0];
        exu_pkg::ialu_cmd_srl  : return a >> b[4:0];
        exu_pkg::ialu_cmd_sra  : return $signed(a) >>> b[4:0];
        exu_pkg::ialu_cmd_slt  : return {31'b0, $signed(a) < $signed(b)};
        exu_pkg::ialu_cmd_sltu : return {31'b0, a < b};
        default                : return '0;
    endcase
endfunction

function automatic logic compare_model(exu_pkg::ialu_cmd_e c, logic [31:0] a, logic [31:0] b);
    case (c)
        exu_pkg::ialu_cmd_eq   : return a == b;
        exu_pkg::ialu_cmd_ne   : return a != b;
        exu_pkg::ialu_cmd_slt  : return $signed(a) < $signed(b);   // blt
        exu_pkg::ialu_cmd_ge   : return $signed(a) >= $signed(b);
        exu_pkg::ialu_cmd_sltu : return a < b;                     // bltu
        exu_pkg::ialu_cmd_geu  : return a >= b;
        default                : return 1'b0;
    endcase
endfunction

task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    assert (got === exp) else begin
        $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
        errors++;
    end
endtask

// Inputs still hold the command accepted at the last rising edge
task automatic check_exec(output logic redir);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s2;
    logic [31:0] target;
    logic [31:0] wdata;
    logic        taken;
    logic        exc;
    logic        wb;
    check_val("curr_pc", curr_pc, mpc);
    check_bit("instret", instret, p_vld);
    redir = 1'b0;
    if (!p_vld) begin
        check_bit("rd_w_req", rd_w_req, 1'b0);
        check_bit("new_pc_req", new_pc_req, 1'b0);
    end else begin
        a      = mreg[rs1_addr];
        b      = (ialu_op == exu_pkg::ialu_op_reg_imm) ? imm : mreg[rs2_addr];
        s2     = ((sum2_op == exu_pkg::sum2_op_reg_imm) ? a : mpc) + imm;
        target = s2 & exu_pkg::jump_mask;
        taken  = jump_req | (branch_req & compare_model(ialu_cmd, a, b));
        exc    = taken & target[1];                 // Word-misaligned target
        wb     = (rd_wb_sel != exu_pkg::rd_wb_none) & ~exc;
        case (rd_wb_sel)
            exu_pkg::rd_wb_sum2   : wdata = s2;
            exu_pkg::rd_wb_imm    : wdata = imm;
            exu_pkg::rd_wb_inc_pc : wdata = mpc + 32'd4;
            default               : wdata = alu_model(ialu_cmd, a, b);
        endcase
        check_bit("exc_req", exc_req, exc);
        check_bit("new_pc_req", new_pc_req, taken);
        check_bit("rd_w_req", rd_w_req, wb);
        if (taken) begin
            check_val("new_pc", new_pc, exc ? exu_pkg::trap_vector : target);
        end
        if (wb) begin
            check_val("rd_w_addr", 32'(rd_w_addr), 32'(rd_addr));
            check_val("rd_w_data", rd_w_data, wdata);
            if (rd_addr != '0) mreg[rd_addr] = wdata;
        end
        mpc   = taken ? (exc ? exu_pkg::trap_vector : target) : mpc + 32'd4;
        redir = taken;
    end
endtask

// --------------------
// Stimulus helpers
// --------------------
// Offers a command every cycle until one gets past a redirect
task automatic send(input exu_pkg::ialu_op_e op, input exu_pkg::ialu_cmd_e cmd,
                    input exu_pkg::sum2_op_e s2op, input exu_pkg::rd_wb_sel_e wb,
                    input logic jmp, input logic br, input logic [4:0] r1,
                    input logic [4:0] r2, input logic [4:0] rd, input logic [31:0] value);
    logic redir;
    logic accepted;                                 // Command got into the queue
    accepted = 1'b0;
    while (!accepted) begin
        check_exec(redir);
        cmd_req    = 1'b1;
        ialu_op    = op;
        ialu_cmd   = cmd;
        sum2_op    = s2op;
        rd_wb_sel  = wb;
        jump_req   = jmp;
        branch_req = br;
        rs1_addr   = r1;
        rs2_addr   = r2;
        rd_addr    = rd;
        imm        = value;
        p_vld      = ~redir;                        // Flushed behind a redirect
        accepted   = ~redir;
        if (redir) drops++;
        @(posedge clk);
        @(negedge clk);
    end
endtask

task automatic idle();
    logic redir;
    check_exec(redir);
    cmd_req = 1'b0;
    p_vld   = 1'b0;
    @(posedge clk);
    @(negedge clk);
endtask

task automatic print_counts();
    $display("Errors: %0d value, %0d assertion, %0d timeout",
             errors, dut0.chk0.fail_cnt, timeouts);
endtask

// --------------------
// Test sequence
// --------------------
initial begin
    exu_pkg::ialu_op_e   op;
    exu_pkg::ialu_cmd_e  cmd;
    logic [4:0]          r1;
    logic [4:0]          r2;
    logic [4:0]          rd;
    int                  pulses;
    void'($urandom(32'h1d3e_f098));
    rst_n      = 1'b0;
    cmd_req    = 1'b0;
    ialu_op    = exu_pkg::ialu_op_reg_reg;
    ialu_cmd   = exu_pkg::ialu_cmd_none;
    sum2_op    = exu_pkg::sum2_op_pc_imm;
    rd_wb_sel  = exu_pkg::rd_wb_none;
    jump_req   = 1'b0;
    branch_req = 1'b0;
    rs1_addr   = '0;
    rs2_addr   = '0;
    rd_addr    = '0;
    imm        = '0;
    p_vld      = 1'b0;
    mpc        = exu_pkg::rst_vector;
    foreach (mreg[i]) begin
        mreg[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_bit("cmd_rdy", cmd_rdy, 1'b0);           // State held in reset
    check_bit("instret", instret, 1'b0);
    check_bit("new_pc_req", new_pc_req, 1'b0);
    check_bit("rd_w_req", rd_w_req, 1'b0);
    check_bit("exc_req", exc_req, 1'b0);
    check_val("curr_pc", curr_pc, exu_pkg::rst_vector);
    rst_n  = 1'b1;

    // Reset exit pulse, then decode opens
    pulses = 0;
    while (!cmd_rdy) begin
        @(negedge clk);
        if (new_pc_req) begin
            pulses++;
            check_val("new_pc", new_pc, exu_pkg::rst_vector);
        end
    end
    assert (pulses == 1) else begin
        $display("Reset exit gave %0d new_pc_req pulses instead of one", pulses);
        errors++;
    end

    // Load every register with lui
    for (int i = 1; i < 32; i++) begin
        send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_none, exu_pkg::sum2_op_pc_imm,
             exu_pkg::rd_wb_imm, 1'b0, 1'b0, 5'd0, 5'd0, 5'(i), $urandom);
    end

    // Random ALU traffic, rd = x0 included
    repeat (300) begin
        op  = exu_pkg::ialu_op_e'(1'($urandom_range(1, 0)));
        cmd = exu_pkg::ialu_cmd_e'(4'($urandom_range(10, 1)));
        send(op, cmd, exu_pkg::sum2_op_pc_imm, exu_pkg::rd_wb_ialu, 1'b0, 1'b0,
             5'($urandom), 5'($urandom), 5'($urandom), $urandom);
        if ($urandom_range(7, 0) == 0) idle();
    end

    // auipc, jal and jalr
    repeat (20) begin
        send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_none, exu_pkg::sum2_op_pc_imm,
             exu_pkg::rd_wb_sum2, 1'b0, 1'b0, 5'd0, 5'd0, 5'($urandom), $urandom);
    end
    repeat (30) begin
        send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_none, exu_pkg::sum2_op_pc_imm,
             exu_pkg::rd_wb_inc_pc, 1'b1, 1'b0, 5'd0, 5'd0, 5'($urandom),
             $urandom & 32'h0000_0ffd);             // Bit 0 random, bit 1 clear
        send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_none, exu_pkg::sum2_op_reg_imm,
             exu_pkg::rd_wb_inc_pc, 1'b1, 1'b0, 5'($urandom), 5'd0, 5'($urandom),
             $urandom & 32'h0000_0fff);             // jalr, may trap
    end

    // Branches, equal operands now and then
    repeat (60) begin
        r1 = 5'($urandom);
        r2 = ($urandom_range(3, 0) == 0) ? r1 : 5'($urandom);
        send(exu_pkg::ialu_op_reg_reg, br_cmds[$urandom_range(5, 0)], exu_pkg::sum2_op_pc_imm,
             exu_pkg::rd_wb_none, 1'b0, 1'b1, r1, r2, 5'd0, $urandom & 32'h0000_0ffc);
    end

    // Misaligned targets from jal and a taken beq
    send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_none, exu_pkg::sum2_op_pc_imm,
         exu_pkg::rd_wb_inc_pc, 1'b1, 1'b0, 5'd0, 5'd0, 5'd7, 32'h0000_0042);
    send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_eq, exu_pkg::sum2_op_pc_imm,
         exu_pkg::rd_wb_none, 1'b0, 1'b1, 5'd3, 5'd3, 5'd0, 32'h0000_0006);
    send(exu_pkg::ialu_op_reg_reg, exu_pkg::ialu_cmd_none, exu_pkg::sum2_op_pc_imm,
         exu_pkg::rd_wb_inc_pc, 1'b1, 1'b0, 5'd0, 5'd0, 5'd9, 32'hffff_fff2);

    // Dependent chain, each command reads the last rd
    r1 = 5'd1;
    repeat (100) begin
        rd  = 5'($urandom_range(31, 1));
        op  = exu_pkg::ialu_op_e'(1'($urandom_range(1, 0)));
        cmd = exu_pkg::ialu_cmd_e'(4'($urandom_range(10, 1)));
        send(op, cmd, exu_pkg::sum2_op_pc_imm, exu_pkg::rd_wb_ialu, 1'b0, 1'b0,
             r1, r1, rd, $urandom);
        r1 = rd;
    end
    idle();
    idle();

    assert (drops > 0) else begin
        $display("No command was offered during a redirect cycle");
        errors++;
    end
    print_counts();
    if (errors + dut0.chk0.fail_cnt + timeouts == 0) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

// Cycle limit
initial begin
    while (cycles < max_cycles) begin
        @(posedge clk);
        cycles++;
    end
    timeouts = 1;
    $display("Run did not finish within %0d cycles", max_cycles);
    print_counts();
    $display(">>> FAIL");
    $finish;
end

endmodule : tb_exu
